//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_alu_core
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the simulator's own exit status is ignored, the log decides
run: compile
	-$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Test FAILED" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	elif ! grep -q "Test OK" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; exit 1; \
	fi
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- dv/alu_stimulus.txt
# gap  instr     result    zero  div_zero
# gap is idle cycles before the instruction, words in hex, flags 0 or 1
0 08800064 00000064 0 0
0 0907fff9 fffffff9 0 0
0 09800003 00000003 0 0
0 0a800000 00000000 1 0
0 03098000 00000067 0 0
0 13098000 00000000 1 0
0 23098000 00000067 0 0
0 33098000 00000067 0 0
0 43098000 ffffffff 0 0
0 53098000 ffffff98 0 0
0 63098000 ffffff98 0 0
0 73188000 00000001 0 0
0 83098000 00000320 0 0
0 93118000 1fffffff 0 0
0 a3118000 ffffffff 0 0
0 b3098000 0000012c 0 0
0 c3098000 00000021 0 0
0 d3098000 00000001 0 0
0 eb080004 00000640 0 0
0 f3098000 00000000 1 0
1 c30a8000 00000000 1 1
0 d30a8000 00000000 1 1
0 0b800005 00000005 0 0
0 043b8000 0000000a 0 0
0 b4c38000 00000032 0 0
2 0b800005 00000005 0 0
2 043b8000 0000000a 0 0
2 b4c38000 00000032 0 0
3 08000037 00000037 0 0
0 05008000 00000064 0 0
2 05818000 00000003 0 0

//--- dv/tb_alu_core.sv
`timescale 1ns/1ps

module tb_alu_core;

    localparam int DRAIN_TIMEOUT = 100;  // cycles
    localparam int MAX_GAP       = 64;

    typedef struct packed {
        logic [alu_pkg::REG_AW-1:0] rd;
        logic [31:0]                result;
        logic                       zero;
        logic                       div_zero;
    } expect_t;

    logic                       clk = 1'b0;
    logic                       rst_n;
    logic                       instr_valid;
    logic [31:0]                instr;
    logic                       result_valid;
    logic [alu_pkg::REG_AW-1:0] result_rd;
    logic [31:0]                result;
    logic                       zero;
    logic                       div_zero;
    logic [15:0]                retired_count;

    expect_t expect_q[$];  // oldest outstanding instruction at the front
    expect_t head;
    int      issued  = 0;

    alu_core_top u_alu_core_top (
        .clk           (clk),
        .rst_n         (rst_n),
        .instr_valid   (instr_valid),
        .instr         (instr),
        .result_valid  (result_valid),
        .result_rd     (result_rd),
        .result        (result),
        .zero          (zero),
        .div_zero      (div_zero),
        .retired_count (retired_count)
    );

    always #50 clk = ~clk;

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Test FAILED");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("mismatch %s: got 0x%08h, expected 0x%08h", name, got, exp));
        end
    endtask

    // outputs settle after the rising edge, so sample on the falling one
    always @(negedge clk) begin
        if (result_valid === 1'b1) begin
            if (expect_q.size() == 0) begin
                fail_run("result_valid went high with no instruction outstanding");
            end else begin
                head = expect_q.pop_front();
                check_eq("result_rd", {28'h0, result_rd}, {28'h0, head.rd});
                check_eq("result", result, head.result);
                check_eq("zero", {31'h0, zero}, {31'h0, head.zero});
                check_eq("div_zero", {31'h0, div_zero}, {31'h0, head.div_zero});
            end
        end
    end

    initial begin
        int          fd;
        int          n;
        int          gap;
        int          z;
        int          dz;
        int          waited;
        string       line;
        logic [31:0] word;
        logic [31:0] res;
        expect_t     e;

        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;

        fd = $fopen("dv/alu_stimulus.txt", "r");
        if (fd == 0) begin
            fail_run("could not open the stimulus file dv/alu_stimulus.txt");
        end

        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n == 0 || line.len() < 2 || line.getc(0) == "#") begin
                continue;  // blank or comment line
            end
            n = $sscanf(line, "%d %h %h %d %d", gap, word, res, z, dz);
            if (n != 5) begin
                fail_run($sformatf("could not parse stimulus line: %s", line));
            end
            if (gap < 0 || gap > MAX_GAP) begin
                fail_run($sformatf("gap count out of range in stimulus line: %s", line));
            end
            repeat (gap) begin
                instr_valid = 1'b0;
                @(negedge clk);
            end
            e.rd       = word[26:23];  // rd is at the same bits in both forms
            e.result   = res;
            e.zero     = (z != 0);
            e.div_zero = (dz != 0);
            expect_q.push_back(e);
            instr_valid = 1'b1;
            instr       = word;
            issued++;
            @(negedge clk);
        end
        instr_valid = 1'b0;
        instr       = '0;
        $fclose(fd);

        waited = 0;
        while (expect_q.size() != 0) begin
            if (waited == DRAIN_TIMEOUT) begin
                fail_run("timed out waiting for the last results to retire");
            end
            @(negedge clk);
            waited++;
        end

        check_eq("retired_count", {16'h0, retired_count}, issued);
        if (issued == 0) begin
            fail_run("no instructions were found in the stimulus file");
        end else begin
            $display("Test OK");
            $finish;
        end
    end

endmodule

//--- src.f
src/alu_pkg.sv
src/issue_if.sv
src/retire_if.sv
src/insn_decode.sv
src/reg_file.sv
src/alu_32bit.sv
src/exec_stage.sv
src/result_out.sv
src/alu_core_top.sv
dv/tb_alu_core.sv

//--- src/alu_32bit.sv
`timescale 1ns/1ps

module alu_32bit (
    input  logic [31:0]      a,
    input  logic [31:0]      b,
    input  alu_pkg::alu_op_e op,
    output logic [31:0]      result,
    output logic             zero,
    output logic             div_by_zero
);

    logic [4:0]  shamt;
    logic        b_is_zero;
    logic [31:0] sum;
    logic [31:0] slt_res;
    logic [31:0] sll_res;
    logic [31:0] srl_res;
    logic [31:0] sra_res;
    logic [31:0] mul_res;
    logic [31:0] div_res;
    logic [31:0] rem_res;

    assign shamt     = b[4:0];
    assign b_is_zero = (b == 32'h0);

    assign sum     = a + b;
    assign slt_res = (a < b) ? 32'h1 : 32'h0;  // unsigned
    assign sll_res = a << shamt;
    assign srl_res = a >> shamt;
    assign sra_res = $signed(a) >>> shamt;
    assign mul_res = a * b;

    // quotient and remainder forced to zero on a zero divisor
    assign div_res = b_is_zero ? 32'h0 : a / b;
    assign rem_res = b_is_zero ? 32'h0 : a % b;

    always_comb begin
        case (op)
            alu_pkg::OP_ADD:  result = sum;
            alu_pkg::OP_AND:  result = a & b;
            alu_pkg::OP_OR:   result = a | b;
            alu_pkg::OP_XOR:  result = a ^ b;
            alu_pkg::OP_NAND: result = ~(a & b);
            alu_pkg::OP_NOR:  result = ~(a | b);
            alu_pkg::OP_XNOR: result = ~(a ^ b);
            alu_pkg::OP_SLT:  result = slt_res;
            alu_pkg::OP_SLL:  result = sll_res;
            alu_pkg::OP_SRL:  result = srl_res;
            alu_pkg::OP_SRA:  result = sra_res;
            alu_pkg::OP_MUL:  result = mul_res;
            alu_pkg::OP_DIV:  result = div_res;
            alu_pkg::OP_REM:  result = rem_res;
            alu_pkg::OP_SLLI: result = sll_res;  // same as sll with b taken from imm
            default:          result = 32'h0;
        endcase
    end

    assign zero = (result == 32'h0);

    always_comb begin
        div_by_zero = 1'b0;
        if (op == alu_pkg::OP_DIV || op == alu_pkg::OP_REM) begin
            div_by_zero = b_is_zero;
        end
    end

endmodule

//--- src/alu_core_top.sv
`timescale 1ns/1ps

module alu_core_top (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       instr_valid,
    input  logic [31:0]                instr,
    output logic                       result_valid,
    output logic [alu_pkg::REG_AW-1:0] result_rd,
    output logic [31:0]                result,
    output logic                       zero,
    output logic                       div_zero,
    output logic [15:0]                retired_count
);

    issue_if  iss ();
    retire_if ret ();

    insn_decode u_insn_decode (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .iss         (iss.dec)
    );

    exec_stage u_exec_stage (
        .clk   (clk),
        .rst_n (rst_n),
        .iss   (iss.exe),
        .ret   (ret.exe)
    );

    result_out u_result_out (
        .clk           (clk),
        .rst_n         (rst_n),
        .ret           (ret.out),
        .result_valid  (result_valid),
        .result_rd     (result_rd),
        .result        (result),
        .zero          (zero),
        .div_zero      (div_zero),
        .retired_count (retired_count)
    );

endmodule

//--- src/alu_pkg.sv
package alu_pkg;

    localparam int NUM_REGS = 16;
    localparam int REG_AW   = 4;

    // alu operation codes
    typedef enum logic [3:0] {
        OP_ADD  = 4'b0000,
        OP_AND  = 4'b0001,
        OP_OR   = 4'b0010,
        OP_XOR  = 4'b0011,
        OP_NAND = 4'b0100,
        OP_NOR  = 4'b0101,
        OP_XNOR = 4'b0110,
        OP_SLT  = 4'b0111,  // unsigned compare
        OP_SLL  = 4'b1000,
        OP_SRL  = 4'b1001,
        OP_SRA  = 4'b1010,
        OP_MUL  = 4'b1011,
        OP_DIV  = 4'b1100,
        OP_REM  = 4'b1101,
        OP_SLLI = 4'b1110,
        OP_RSVD = 4'b1111   // result is zero
    } alu_op_e;

    // register form when use_imm is 0
    typedef struct packed {
        alu_op_e           op;
        logic              use_imm;
        logic [REG_AW-1:0] rd;
        logic [REG_AW-1:0] rs1;
        logic [REG_AW-1:0] rs2;
        logic [14:0]       pad;
    } r_fmt_t;

    // immediate form when use_imm is 1
    typedef struct packed {
        alu_op_e           op;
        logic              use_imm;
        logic [REG_AW-1:0] rd;
        logic [REG_AW-1:0] rs1;
        logic [18:0]       imm;  // sign-extended on decode
    } i_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } instr_u;

endpackage

//--- src/exec_stage.sv
`timescale 1ns/1ps

module exec_stage (
    input  logic clk,
    input  logic rst_n,
    issue_if.exe iss,
    retire_if.exe ret
);

    logic [31:0] ra_data;
    logic [31:0] rb_data;
    logic        fwd_a;
    logic        fwd_b;
    logic [31:0] op_a;
    logic [31:0] op_b;
    logic [31:0] alu_result;
    logic        alu_zero;
    logic        alu_div_zero;

    // result register and write-back source
    logic                       res_valid;
    logic [alu_pkg::REG_AW-1:0] res_rd;
    logic [31:0]                res_q;
    logic                       res_zero;
    logic                       res_div_zero;

    reg_file u_reg_file (
        .clk     (clk),
        .rst_n   (rst_n),
        .ra_addr (iss.rs1),
        .rb_addr (iss.rs2),
        .ra_data (ra_data),
        .rb_data (rb_data),
        .we      (res_valid),
        .wa      (res_rd),
        .wd      (res_q)
    );

    // previous instruction still sits in the result register
    assign fwd_a = res_valid && (res_rd != '0) && (res_rd == iss.rs1);
    assign fwd_b = res_valid && (res_rd != '0) && (res_rd == iss.rs2);

    assign op_a = fwd_a ? res_q : ra_data;
    assign op_b = iss.use_imm ? iss.imm : (fwd_b ? res_q : rb_data);

    alu_32bit u_alu (
        .a           (op_a),
        .b           (op_b),
        .op          (iss.op),
        .result      (alu_result),
        .zero        (alu_zero),
        .div_by_zero (alu_div_zero)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= iss.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (iss.valid) begin
            res_rd       <= iss.rd;
            res_q        <= alu_result;
            res_zero     <= alu_zero;
            res_div_zero <= alu_div_zero;
        end
    end

    assign ret.valid    = res_valid;
    assign ret.rd       = res_rd;
    assign ret.result   = res_q;
    assign ret.zero     = res_zero;
    assign ret.div_zero = res_div_zero;

    a_op_known: assert property (@(posedge clk) disable iff (!rst_n)
        iss.valid |-> !$isunknown(iss.op));

endmodule

//--- src/insn_decode.sv
`timescale 1ns/1ps

module insn_decode (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        instr_valid,
    input  logic [31:0] instr,
    issue_if.dec        iss
);

    alu_pkg::instr_u word;

    logic                       valid_q;
    alu_pkg::alu_op_e           op_q;
    logic [alu_pkg::REG_AW-1:0] rd_q;
    logic [alu_pkg::REG_AW-1:0] rs1_q;
    logic [alu_pkg::REG_AW-1:0] rs2_q;
    logic                       use_imm_q;
    logic [31:0]                imm_q;

    assign word = instr;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= instr_valid;
        end
    end

    // fields only load with a new word
    always_ff @(posedge clk) begin
        if (instr_valid) begin
            op_q      <= word.r.op;  // op and use_imm sit at the same bits in both forms
            use_imm_q <= word.r.use_imm;
            if (word.r.use_imm) begin
                rd_q  <= word.i.rd;
                rs1_q <= word.i.rs1;
                rs2_q <= '0;
                imm_q <= {{13{word.i.imm[18]}}, word.i.imm};
            end else begin
                rd_q  <= word.r.rd;
                rs1_q <= word.r.rs1;
                rs2_q <= word.r.rs2;
                imm_q <= '0;
            end
        end
    end

    assign iss.valid   = valid_q;
    assign iss.op      = op_q;
    assign iss.rd      = rd_q;
    assign iss.rs1     = rs1_q;
    assign iss.rs2     = rs2_q;
    assign iss.use_imm = use_imm_q;
    assign iss.imm     = imm_q;

    a_instr_known: assert property (@(posedge clk) disable iff (!rst_n)
        instr_valid |-> !$isunknown(instr));

endmodule

//--- src/issue_if.sv
`timescale 1ns/1ps

// decoded instruction from decode to execute
interface issue_if;

    logic                      valid;
    alu_pkg::alu_op_e          op;
    logic [alu_pkg::REG_AW-1:0] rd;
    logic [alu_pkg::REG_AW-1:0] rs1;
    logic [alu_pkg::REG_AW-1:0] rs2;
    logic                      use_imm;
    logic [31:0]               imm;  // already sign-extended

    modport dec (
        output valid, op, rd, rs1, rs2, use_imm, imm
    );

    modport exe (
        input valid, op, rd, rs1, rs2, use_imm, imm
    );

endinterface

//--- src/reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [alu_pkg::REG_AW-1:0] ra_addr,
    input  logic [alu_pkg::REG_AW-1:0] rb_addr,
    output logic [31:0]                ra_data,
    output logic [31:0]                rb_data,
    input  logic                       we,
    input  logic [alu_pkg::REG_AW-1:0] wa,
    input  logic [31:0]                wd
);

    logic [31:0] regs [alu_pkg::NUM_REGS];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < alu_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wa != '0) begin  // r0 writes dropped
            regs[wa] <= wd;
        end
    end

    // combinational reads
    assign ra_data = regs[ra_addr];
    assign rb_data = regs[rb_addr];

    a_r0_zero: assert property (@(posedge clk) disable iff (!rst_n)
        (ra_addr == '0) |-> (ra_data == '0));

endmodule

//--- src/result_out.sv
`timescale 1ns/1ps

module result_out (
    input  logic                       clk,
    input  logic                       rst_n,
    retire_if.out                      ret,
    output logic                       result_valid,
    output logic [alu_pkg::REG_AW-1:0] result_rd,
    output logic [31:0]                result,
    output logic                       zero,
    output logic                       div_zero,
    output logic [15:0]                retired_count
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result_valid  <= 1'b0;
            retired_count <= '0;
        end else begin
            result_valid <= ret.valid;
            if (ret.valid) begin
                retired_count <= retired_count + 16'd1;  // wraps
            end
        end
    end

    // payload held between results
    always_ff @(posedge clk) begin
        if (ret.valid) begin
            result_rd <= ret.rd;
            result    <= ret.result;
            zero      <= ret.zero;
            div_zero  <= ret.div_zero;
        end
    end

endmodule

//--- src/retire_if.sv
`timescale 1ns/1ps

// executed result from execute to output
interface retire_if;

    logic                       valid;
    logic [alu_pkg::REG_AW-1:0] rd;
    logic [31:0]                result;
    logic                       zero;
    logic                       div_zero;

    modport exe (
        output valid, rd, result, zero, div_zero
    );

    modport out (
        input valid, rd, result, zero, div_zero
    );

endinterface
